//--- design/issue_pkg.sv
package issue_pkg;

    localparam int unsigned SB_DEPTH = 8;
    localparam int unsigned TAG_W    = 3;
    localparam int unsigned NR_AREGS = 32;

    typedef logic [4:0]       areg_t;
    typedef logic [TAG_W-1:0] tag_t;   // entry index, also the transaction id
    typedef logic [TAG_W:0]   cnt_t;   // 0 .. SB_DEPTH
    typedef logic [31:0]      xlen_t;
    typedef logic [31:0]      pc_t;
    typedef logic [5:0]       op_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        op_t   op;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
    } decode_req_t;

    typedef struct packed {
        logic renamed;
        tag_t tag;
    } src_map_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        op_t   op;
        tag_t  tag;
        xlen_t operand_1;
        xlen_t operand_2;
    } issue_req_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        xlen_t data;
    } wb_t;

    typedef struct packed {
        logic  we;
        areg_t rd;
        xlen_t data;
        pc_t   pc;
    } commit_t;

    // one scoreboard slot
    typedef struct packed {
        logic  busy;
        logic  issued;
        logic  done;      // result written back
        pc_t   pc;
        op_t   op;
        areg_t rd;
        logic  rs1_rdy;
        tag_t  rs1_tag;
        xlen_t rs1_data;
        logic  rs2_rdy;
        tag_t  rs2_tag;
        xlen_t rs2_data;
        xlen_t result;
    } sb_entry_t;

endpackage

//--- design/rename_table.sv
`timescale 1ns/1ps

module rename_table (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                alloc_i,
    input  issue_pkg::areg_t    alloc_rd_i,
    input  issue_pkg::tag_t     alloc_tag_i,
    input  issue_pkg::areg_t    rs1_i,
    input  issue_pkg::areg_t    rs2_i,
    input  logic                release_i,
    input  issue_pkg::areg_t    release_rd_i,
    input  issue_pkg::tag_t     release_tag_i,
    output issue_pkg::src_map_t rs1_map_o,
    output issue_pkg::src_map_t rs2_map_o
);
    import issue_pkg::*;

    logic [NR_AREGS-1:0] renamed_q;
    logic [NR_AREGS-1:0] renamed_d;
    tag_t                tag_q [NR_AREGS];
    logic                alloc_en;
    logic                release_hit;

    assign alloc_en = alloc_i && (alloc_rd_i != '0);  // x0 always reads the regfile

    // only drop the mapping if no younger producer took rd over
    assign release_hit = release_i
                         && renamed_q[release_rd_i]
                         && (tag_q[release_rd_i] == release_tag_i);

    always_comb begin
        rs1_map_o.renamed = renamed_q[rs1_i];
        rs1_map_o.tag     = tag_q[rs1_i];
        rs2_map_o.renamed = renamed_q[rs2_i];
        rs2_map_o.tag     = tag_q[rs2_i];
    end

    always_comb begin
        renamed_d = renamed_q;
        if (release_hit) begin
            renamed_d[release_rd_i] = 1'b0;
        end
        if (alloc_en) begin
            renamed_d[alloc_rd_i] = 1'b1;  // new producer wins over release
        end
        if (flush_i) begin
            renamed_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            renamed_q <= '0;
        end else begin
            renamed_q <= renamed_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_en) begin
            tag_q[alloc_rd_i] <= alloc_tag_i;
        end
    end

    // a live mapping never points back at the slot being handed out
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_en && !release_i |-> !(renamed_q[alloc_rd_i] && tag_q[alloc_rd_i] == alloc_tag_i)
                                   || flush_i);

endmodule

//--- design/scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  issue_pkg::decode_req_t decode_req_i,
    input  issue_pkg::src_map_t    rs1_map_i,
    input  issue_pkg::src_map_t    rs2_map_i,
    input  issue_pkg::xlen_t       regfile_rdata_a_i,
    input  issue_pkg::xlen_t       regfile_rdata_b_i,
    input  issue_pkg::wb_t         wb_i,
    input  logic                   issue_fire_i,
    input  issue_pkg::tag_t        issue_ptr_i,
    input  logic                   commit_fire_i,
    input  issue_pkg::tag_t        commit_ptr_i,
    output logic                   dispatch_ready_o,
    output issue_pkg::tag_t        alloc_tag_o,
    output issue_pkg::sb_entry_t   issue_entry_o,
    output issue_pkg::sb_entry_t   commit_entry_o,
    output issue_pkg::cnt_t        count_o
);
    import issue_pkg::*;

    typedef struct packed {
        logic  rdy;
        xlen_t data;
    } opnd_t;

    sb_entry_t sb_q [SB_DEPTH];
    sb_entry_t sb_d [SB_DEPTH];
    sb_entry_t new_entry;
    tag_t      wptr_q;
    tag_t      wptr_d;
    cnt_t      cnt_q;
    cnt_t      cnt_d;
    logic      full;
    logic      dispatch;
    opnd_t     src1;
    opnd_t     src2;

    // regfile, then same-cycle write-back, then finished producer, else wait
    function automatic opnd_t resolve_src(src_map_t map, xlen_t rf_data, wb_t wb,
                                          sb_entry_t prod);
        opnd_t src;
        src = '0;
        if (!map.renamed) begin
            src.rdy  = 1'b1;
            src.data = rf_data;
        end else if (wb.valid && (wb.tag == map.tag)) begin
            src.rdy  = 1'b1;
            src.data = wb.data;
        end else if (prod.done) begin
            src.rdy  = 1'b1;
            src.data = prod.result;
        end
        return src;
    endfunction

    assign full             = (cnt_q == cnt_t'(SB_DEPTH));
    assign dispatch_ready_o = !full;
    assign dispatch         = decode_req_i.valid && !full;
    assign alloc_tag_o      = wptr_q;
    assign count_o          = cnt_q;
    assign issue_entry_o    = sb_q[issue_ptr_i];
    assign commit_entry_o   = sb_q[commit_ptr_i];

    assign src1 = resolve_src(rs1_map_i, regfile_rdata_a_i, wb_i, sb_q[rs1_map_i.tag]);
    assign src2 = resolve_src(rs2_map_i, regfile_rdata_b_i, wb_i, sb_q[rs2_map_i.tag]);

    always_comb begin
        new_entry          = '0;
        new_entry.busy     = 1'b1;
        new_entry.pc       = decode_req_i.pc;
        new_entry.op       = decode_req_i.op;
        new_entry.rd       = decode_req_i.rd;
        new_entry.rs1_rdy  = src1.rdy;
        new_entry.rs1_tag  = rs1_map_i.tag;
        new_entry.rs1_data = src1.data;
        new_entry.rs2_rdy  = src2.rdy;
        new_entry.rs2_tag  = rs2_map_i.tag;
        new_entry.rs2_data = src2.data;
    end

    always_comb begin
        sb_d = sb_q;
        if (issue_fire_i) begin
            sb_d[issue_ptr_i].issued = 1'b1;
        end
        if (wb_i.valid) begin
            sb_d[wb_i.tag].done   = 1'b1;
            sb_d[wb_i.tag].result = wb_i.data;
        end
        // wake-up of waiting operands
        for (int unsigned i = 0; i < SB_DEPTH; i++) begin
            if (wb_i.valid && sb_q[i].busy) begin
                if (!sb_q[i].rs1_rdy && (sb_q[i].rs1_tag == wb_i.tag)) begin
                    sb_d[i].rs1_rdy  = 1'b1;
                    sb_d[i].rs1_data = wb_i.data;
                end
                if (!sb_q[i].rs2_rdy && (sb_q[i].rs2_tag == wb_i.tag)) begin
                    sb_d[i].rs2_rdy  = 1'b1;
                    sb_d[i].rs2_data = wb_i.data;
                end
            end
        end
        if (commit_fire_i) begin
            sb_d[commit_ptr_i] = '0;
        end
        if (dispatch) begin
            sb_d[wptr_q] = new_entry;  // slot is free, commit never hits it here
        end
        if (flush_i) begin
            sb_d = '{default: '0};
        end
    end

    always_comb begin
        wptr_d = wptr_q;
        if (dispatch) begin
            wptr_d = wptr_q + 1'b1;  // wraps at SB_DEPTH
        end
        cnt_d = cnt_q + cnt_t'(dispatch) - cnt_t'(commit_fire_i);
        if (flush_i) begin
            wptr_d = '0;
            cnt_d  = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sb_q   <= '{default: '0};
            wptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            sb_q   <= sb_d;
            wptr_q <= wptr_d;
            cnt_q  <= cnt_d;
        end
    end

    // count and pointers agree, so dispatch only lands in a free slot
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        dispatch |-> !sb_q[wptr_q].busy);

    // execute may only answer an issued, still pending entry
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_i.valid |-> sb_q[wb_i.tag].busy && sb_q[wb_i.tag].issued
                       && !sb_q[wb_i.tag].done);

endmodule

//--- design/issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  issue_pkg::sb_entry_t  issue_entry_i,
    input  logic                  ex_ready_i,
    input  issue_pkg::cnt_t       count_i,
    output issue_pkg::issue_req_t issue_o,
    output logic                  issue_fire_o,
    output issue_pkg::tag_t       issue_ptr_o
);
    import issue_pkg::*;

    tag_t ptr_q;
    logic head_ready;

    assign head_ready = (count_i != '0)
                        && issue_entry_i.busy
                        && !issue_entry_i.issued
                        && issue_entry_i.rs1_rdy
                        && issue_entry_i.rs2_rdy;

    always_comb begin
        issue_o.valid     = head_ready && !flush_i;
        issue_o.pc        = issue_entry_i.pc;
        issue_o.op        = issue_entry_i.op;
        issue_o.tag       = ptr_q;
        issue_o.operand_1 = issue_entry_i.rs1_data;
        issue_o.operand_2 = issue_entry_i.rs2_data;
    end

    assign issue_fire_o = issue_o.valid && ex_ready_i;
    assign issue_ptr_o  = ptr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (flush_i) begin
            ptr_q <= '0;
        end else if (issue_fire_o) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    // stalled request holds until execute takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_o.valid && !ex_ready_i |=> flush_i || (issue_o.valid && $stable(issue_o)));

endmodule

//--- design/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  issue_pkg::sb_entry_t commit_entry_i,
    input  logic                 commit_ack_i,
    output issue_pkg::commit_t   commit_o,
    output logic                 commit_fire_o,
    output issue_pkg::tag_t      commit_ptr_o,
    output issue_pkg::areg_t     release_rd_o,
    output issue_pkg::tag_t      release_tag_o
);
    import issue_pkg::*;

    tag_t ptr_q;
    logic head_done;

    assign head_done     = commit_entry_i.busy && commit_entry_i.done;
    assign commit_fire_o = head_done && commit_ack_i && !flush_i;

    always_comb begin
        commit_o.we   = commit_fire_o;
        commit_o.rd   = commit_entry_i.rd;
        commit_o.data = commit_entry_i.result;
        commit_o.pc   = commit_entry_i.pc;
    end

    assign commit_ptr_o  = ptr_q;
    assign release_rd_o  = commit_entry_i.rd;
    assign release_tag_o = ptr_q;  // slot index is the producer tag

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (flush_i) begin
            ptr_q <= '0;
        end else if (commit_fire_o) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    // a retiring entry was issued before its result came back
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_fire_o |-> commit_entry_i.issued);

endmodule

//--- design/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  issue_pkg::decode_req_t decode_req_i,
    output logic                   dispatch_ready_o,
    output issue_pkg::areg_t       regfile_raddr_a_o,
    output issue_pkg::areg_t       regfile_raddr_b_o,
    input  issue_pkg::xlen_t       regfile_rdata_a_i,
    input  issue_pkg::xlen_t       regfile_rdata_b_i,
    output issue_pkg::issue_req_t  issue_o,
    input  logic                   ex_ready_i,
    input  issue_pkg::wb_t         wb_i,
    input  logic                   commit_ack_i,
    output issue_pkg::commit_t     commit_o
);
    import issue_pkg::*;

    src_map_t  rs1_map;
    src_map_t  rs2_map;
    tag_t      alloc_tag;
    logic      dispatch_fire;
    sb_entry_t issue_entry;
    sb_entry_t commit_entry;
    cnt_t      count;
    logic      issue_fire;
    tag_t      issue_ptr;
    logic      commit_fire;
    tag_t      commit_ptr;
    areg_t     release_rd;
    tag_t      release_tag;

    assign dispatch_fire     = decode_req_i.valid && dispatch_ready_o;
    assign regfile_raddr_a_o = decode_req_i.rs1;
    assign regfile_raddr_b_o = decode_req_i.rs2;

    rename_table u_rename_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .alloc_i       (dispatch_fire),
        .alloc_rd_i    (decode_req_i.rd),
        .alloc_tag_i   (alloc_tag),
        .rs1_i         (decode_req_i.rs1),
        .rs2_i         (decode_req_i.rs2),
        .release_i     (commit_fire),
        .release_rd_i  (release_rd),
        .release_tag_i (release_tag),
        .rs1_map_o     (rs1_map),
        .rs2_map_o     (rs2_map)
    );

    scoreboard u_scoreboard (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .decode_req_i      (decode_req_i),
        .rs1_map_i         (rs1_map),
        .rs2_map_i         (rs2_map),
        .regfile_rdata_a_i (regfile_rdata_a_i),
        .regfile_rdata_b_i (regfile_rdata_b_i),
        .wb_i              (wb_i),
        .issue_fire_i      (issue_fire),
        .issue_ptr_i       (issue_ptr),
        .commit_fire_i     (commit_fire),
        .commit_ptr_i      (commit_ptr),
        .dispatch_ready_o  (dispatch_ready_o),
        .alloc_tag_o       (alloc_tag),
        .issue_entry_o     (issue_entry),
        .commit_entry_o    (commit_entry),
        .count_o           (count)
    );

    issue_select u_issue_select (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .issue_entry_i (issue_entry),
        .ex_ready_i    (ex_ready_i),
        .count_i       (count),
        .issue_o       (issue_o),
        .issue_fire_o  (issue_fire),
        .issue_ptr_o   (issue_ptr)
    );

    commit_unit u_commit_unit (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .commit_entry_i (commit_entry),
        .commit_ack_i   (commit_ack_i),
        .commit_o       (commit_o),
        .commit_fire_o  (commit_fire),
        .commit_ptr_o   (commit_ptr),
        .release_rd_o   (release_rd),
        .release_tag_o  (release_tag)
    );

endmodule

//--- testbench/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// program-order register state that runs ahead of the committed regfile
xlen_t       arch_rf [NR_AREGS];
issue_req_t  exp_issue_q [$];
commit_t     exp_commit_q [$];
int unsigned slot_cnt;  // dispatches since reset or flush

// what the execute unit returns for one instruction
function automatic xlen_t exec_result(op_t op, xlen_t a, xlen_t b);
    return a + b + xlen_t'(op);
endfunction

// DUT accepted the instruction so queue what must come out later
function automatic void predict_dispatch(decode_req_t req);
    issue_req_t ei;
    commit_t    ec;
    xlen_t      a;
    xlen_t      b;
    a = arch_rf[req.rs1];  // x0 entry stays zero
    b = arch_rf[req.rs2];

    ei           = '0;
    ei.valid     = 1'b1;
    ei.pc        = req.pc;
    ei.op        = req.op;
    ei.tag       = tag_t'(slot_cnt % SB_DEPTH);
    ei.operand_1 = a;
    ei.operand_2 = b;

    ec.we   = 1'b1;
    ec.rd   = req.rd;
    ec.data = exec_result(req.op, a, b);
    ec.pc   = req.pc;

    if (req.rd != '0) begin
        arch_rf[req.rd] = ec.data;
    end
    slot_cnt++;
    exp_issue_q.push_back(ei);
    exp_commit_q.push_back(ec);
endfunction

// on flush or reset only committed values survive
function automatic void restart_from_regfile();
    for (int unsigned i = 0; i < NR_AREGS; i++) begin
        arch_rf[i] = rf_mem[i];
    end
    exp_issue_q.delete();
    exp_commit_q.delete();
    slot_cnt = 0;
endfunction

`endif

//--- testbench/tb_issue_stage.sv
`timescale 1ns/1ps

module tb_issue_stage;
    import issue_pkg::*;

    localparam int unsigned N_RANDOM = 3000;
    localparam int unsigned WAIT_MAX = 200;  // cycles per wait loop

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    decode_req_t decode_req_i;
    logic        dispatch_ready_o;
    areg_t       regfile_raddr_a_o;
    areg_t       regfile_raddr_b_o;
    xlen_t       regfile_rdata_a_i;
    xlen_t       regfile_rdata_b_i;
    issue_req_t  issue_o;
    logic        ex_ready_i;
    wb_t         wb_i;
    logic        commit_ack_i;
    commit_t     commit_o;

    xlen_t       rf_mem [NR_AREGS];
    wb_t         ex_pool [$];  // issued and waiting for write-back
    pc_t         pc_next;
    logic        stalled;
    issue_req_t  held_issue;
    logic        did_dispatch;
    int unsigned err_value;
    int unsigned err_other;

    `include "issue_model.svh"

    issue_stage UUT (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .decode_req_i      (decode_req_i),
        .dispatch_ready_o  (dispatch_ready_o),
        .regfile_raddr_a_o (regfile_raddr_a_o),
        .regfile_raddr_b_o (regfile_raddr_b_o),
        .regfile_rdata_a_i (regfile_rdata_a_i),
        .regfile_rdata_b_i (regfile_rdata_b_i),
        .issue_o           (issue_o),
        .ex_ready_i        (ex_ready_i),
        .wb_i              (wb_i),
        .commit_ack_i      (commit_ack_i),
        .commit_o          (commit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // register file with x0 hardwired
    always_comb regfile_rdata_a_i = rf_mem[regfile_raddr_a_o];
    always_comb regfile_rdata_b_i = rf_mem[regfile_raddr_b_o];

    always @(posedge clk_i) begin
        if (commit_o.we && (commit_o.rd != '0)) begin
            rf_mem[commit_o.rd] <= commit_o.data;
        end
    end

    task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
            err_value++;
        end
    endtask

    task automatic note_failure(string what);
        $display("FAILURE: %s at %0t", what, $time);
        err_other++;
    endtask

    // mostly x0..x3 so dependences are common
    function automatic areg_t pick_reg();
        if (($urandom % 4) != 0) begin
            return areg_t'($urandom % 4);
        end
        return areg_t'($urandom);
    endfunction

    task automatic observe_cycle();
        issue_req_t exp_i;
        commit_t    exp_c;
        wb_t        res;
        did_dispatch = 1'b0;
        if (stalled && !flush_i) begin
            check_value("issue_hold", held_issue, issue_o);
        end
        if (issue_o.valid && ex_ready_i) begin
            if (exp_issue_q.size() == 0) begin
                note_failure("issue transfer with no instruction in flight");
            end else begin
                exp_i = exp_issue_q.pop_front();
                check_value("issue_pc", exp_i.pc, issue_o.pc);
                check_value("issue_op", exp_i.op, issue_o.op);
                check_value("issue_tag", exp_i.tag, issue_o.tag);
                check_value("issue_operand_1", exp_i.operand_1, issue_o.operand_1);
                check_value("issue_operand_2", exp_i.operand_2, issue_o.operand_2);
            end
            res       = '0;
            res.valid = 1'b1;
            res.tag   = issue_o.tag;
            res.data  = exec_result(issue_o.op, issue_o.operand_1, issue_o.operand_2);
            ex_pool.push_back(res);
        end
        stalled    = issue_o.valid && !ex_ready_i;
        held_issue = issue_o;
        if (commit_o.we) begin
            if (exp_commit_q.size() == 0) begin
                note_failure("register-file write with nothing left to commit");
            end else begin
                exp_c = exp_commit_q.pop_front();
                check_value("commit_rd", exp_c.rd, commit_o.rd);
                check_value("commit_data", exp_c.data, commit_o.data);
                check_value("commit_pc", exp_c.pc, commit_o.pc);
            end
        end
        if (decode_req_i.valid && dispatch_ready_o) begin
            predict_dispatch(decode_req_i);
            pc_next      = pc_next + 32'd4;
            did_dispatch = 1'b1;
        end
        if (flush_i) begin
            ex_pool.delete();
            restart_from_regfile();
            stalled = 1'b0;
        end
    endtask

    // drive on the falling edge, look just before the rising one
    task automatic run_cycle(int unsigned dec_pct, int unsigned ack_pct, logic do_flush);
        int unsigned idx;
        @(negedge clk_i);
        flush_i            = do_flush;
        decode_req_i.valid = !do_flush && (($urandom % 100) < dec_pct);
        decode_req_i.pc    = pc_next;
        decode_req_i.op    = op_t'($urandom);
        decode_req_i.rs1   = pick_reg();
        decode_req_i.rs2   = pick_reg();
        decode_req_i.rd    = pick_reg();
        ex_ready_i         = ($urandom % 4) != 0;
        commit_ack_i       = ($urandom % 100) < ack_pct;
        wb_i               = '0;
        if (!do_flush && (ex_pool.size() != 0) && (($urandom % 2) == 1)) begin
            idx  = $urandom % ex_pool.size();
            wb_i = ex_pool[idx];
            ex_pool.delete(idx);
        end
        #1;
        observe_cycle();
    endtask

    task automatic drain_pipeline();
        int unsigned n;
        n = 0;
        while ((exp_commit_q.size() != 0) && (n < WAIT_MAX)) begin
            run_cycle(0, 100, 1'b0);
            n++;
        end
        if (exp_commit_q.size() != 0) begin
            note_failure("timeout, instructions still not committed while draining");
        end
    endtask

    task automatic check_backpressure();
        int unsigned n_disp;
        int unsigned n_commit;
        int unsigned n;
        n_disp   = 0;
        n_commit = 0;
        n        = 0;
        while (dispatch_ready_o && (n < WAIT_MAX)) begin
            run_cycle(100, 0, 1'b0);  // commit blocked
            if (did_dispatch) begin
                n_disp++;
            end
            n++;
        end
        if (dispatch_ready_o) begin
            note_failure("timeout, dispatch ready never dropped with commit blocked");
        end
        check_value("dispatches_until_full", SB_DEPTH, n_disp);
        n = 0;
        while (!dispatch_ready_o && (n < WAIT_MAX)) begin
            run_cycle(0, 100, 1'b0);
            if (commit_o.we && !dispatch_ready_o) begin
                n_commit++;
            end
            n++;
        end
        if (!dispatch_ready_o) begin
            note_failure("timeout, dispatch ready never came back after commit");
        end
        check_value("commits_until_ready", 1, n_commit);  // one free slot is enough
    endtask

    initial begin
        void'($urandom(32'h6a87));
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        decode_req_i = '0;
        ex_ready_i   = 1'b0;
        wb_i         = '0;
        commit_ack_i = 1'b0;
        stalled      = 1'b0;
        held_issue   = '0;
        did_dispatch = 1'b0;
        err_value    = 0;
        err_other    = 0;
        pc_next      = 32'h8000_0000;
        for (int unsigned i = 0; i < NR_AREGS; i++) begin
            rf_mem[i] = xlen_t'(i) * 32'h9e37_79b9;  // zero for x0
        end
        restart_from_regfile();

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        check_value("reset_dispatch_ready", 1'b1, dispatch_ready_o);
        check_value("reset_issue_valid", 1'b0, issue_o.valid);
        check_value("reset_commit_we", 1'b0, commit_o.we);

        for (int unsigned i = 0; i < N_RANDOM; i++) begin
            run_cycle(60, 80, ($urandom % 100) == 0);
        end
        drain_pipeline();
        check_backpressure();
        drain_pipeline();

        // flush with a window in flight
        for (int unsigned i = 0; i < 6; i++) begin
            run_cycle(100, 0, 1'b0);
        end
        run_cycle(0, 0, 1'b1);
        for (int unsigned i = 0; i < 300; i++) begin
            run_cycle(60, 80, 1'b0);
        end
        drain_pipeline();
        check_value("issues_left", 0, exp_issue_q.size());

        $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if ((err_value + err_other) == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+testbench
design/issue_pkg.sv
design/rename_table.sv
design/scoreboard.sv
design/issue_select.sv
design/commit_unit.sv
design/issue_stage.sv
testbench/tb_issue_stage.sv
